// ==== Makefile ====
# Verilator flow for the ALU issue back end
TOP := tb_alu_issue
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP) -o $(TOP)

# pass only if the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== alu_exec.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module alu_exec (
	input logic clk,
	input logic reset,
	input logic stall,
	issue_if.exec ex,
	// operand fetch
	output logic [`IQ_PREG_W-1:0] rf_addr1,
	output logic [`IQ_PREG_W-1:0] rf_addr2,
	input logic [`IQ_XLEN-1:0] rf_data1,
	input logic [`IQ_XLEN-1:0] rf_data2,
	// registered result, also wake 0 and regfile port 0
	output logic wb_valid,
	output logic [`IQ_PREG_W-1:0] wb_tag,
	output logic [`IQ_XLEN-1:0] wb_data
);
	logic [`IQ_XLEN-1:0] opa;
	logic [`IQ_XLEN-1:0] opb;
	logic [`IQ_XLEN-1:0] imm_ext;
	logic [4:0] shamt;
	logic [`IQ_XLEN-1:0] result;
	logic fire;

	// tag view, only meaningful with use_imm clear
	assign rf_addr1 = ex.src1;
	assign rf_addr2 = ex.op2.tag_view[`IQ_PREG_W-1:0];

	// immediate view, sign extended to a full word
	assign imm_ext = {{(`IQ_XLEN - `IQ_IMM_W){ex.op2.imm[`IQ_IMM_W-1]}}, ex.op2.imm};

	assign opa = rf_data1;
	assign opb = ex.use_imm ? imm_ext : rf_data2;
	// shifts use the low five bits only
	assign shamt = opb[4:0];

	always_comb begin
		result = '0;
		case (ex.op)
			`IQ_OP_ADD: result = opa + opb;
			`IQ_OP_SUB: result = opa - opb;
			`IQ_OP_AND: result = opa & opb;
			`IQ_OP_OR: result = opa | opb;
			`IQ_OP_XOR: result = opa ^ opb;
			`IQ_OP_SLL: result = opa << shamt;
			`IQ_OP_SRL: result = opa >> shamt;
			// signed compare, 0 or 1
			`IQ_OP_SLT: result = {{(`IQ_XLEN - 1){1'b0}}, $signed(opa) < $signed(opb)};
			default: result = '0;
		endcase
	end

	// an op leaves the queue only when not stalled
	assign fire = ex.valid && !stall;

	// stall turns into a bubble here
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= fire;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			wb_tag <= ex.dst;
			wb_data <= result;
		end
	end

endmodule

// ==== alu_iqueue.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module alu_iqueue
	import iq_pkg::*;
#(
	parameter int QLEN = `IQ_QLEN
)(
	input logic clk,
	input logic reset,
	input logic disp_en,
	input logic stall,
	input logic [`IQ_OP_W-1:0] disp_op,
	input logic [`IQ_ROB_W-1:0] disp_rob,
	input logic [`IQ_PREG_W-1:0] disp_dst,
	input logic [`IQ_PREG_W-1:0] disp_src1,
	input logic disp_src1_ready,
	input logic disp_use_imm,
	input op2_u disp_op2,
	input logic disp_src2_ready,
	input logic [`IQ_WAKE_NUM-1:0] wake_valid,
	input logic [`IQ_WAKE_NUM-1:0][`IQ_PREG_W-1:0] wake_tag,
	output logic full,
	issue_if.issue iq
);
	localparam int IDX_W = $clog2(QLEN);
	localparam int RIDX_W = `IQ_ROB_W - 1;

	// per-slot control
	logic [QLEN-1:0] valid;
	logic [QLEN-1:0] rdy1;
	logic [QLEN-1:0] rdy2;

	// per-slot payload
	logic [`IQ_OP_W-1:0] op_q [QLEN];
	logic [`IQ_ROB_W-1:0] rob_q [QLEN];
	logic [`IQ_PREG_W-1:0] dst_q [QLEN];
	logic [`IQ_PREG_W-1:0] src1_q [QLEN];
	logic use_imm_q [QLEN];
	op2_u op2_q [QLEN];

	// allocation
	logic [IDX_W-1:0] free_idx;
	logic has_free;
	logic disp_ok;

	// select tree, heap layout, root at 1, leaves at QLEN..2*QLEN-1
	logic node_v [1:2*QLEN-1];
	logic [IDX_W-1:0] node_id [1:2*QLEN-1];
	logic [`IQ_ROB_W-1:0] node_rob [1:2*QLEN-1];

	logic [IDX_W-1:0] chosen;
	logic issue_go;

	// dispatch-time readiness, includes a wake in the same cycle
	logic disp_rdy1;
	logic disp_rdy2;

	// any wake port hitting this tag
	function automatic logic wake_hit(input logic [`IQ_PREG_W-1:0] tag);
		logic hit;
		hit = 1'b0;
		for (int w = 0; w < `IQ_WAKE_NUM; w++) begin
			if (wake_valid[w] && wake_tag[w] == tag) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// a older than b, invalid never wins over valid
	function automatic logic is_older(
		input logic va,
		input logic [`IQ_ROB_W-1:0] ra,
		input logic vb,
		input logic [`IQ_ROB_W-1:0] rb
	);
		logic same_wrap;
		logic a_first;
		same_wrap = ra[`IQ_ROB_W-1] == rb[`IQ_ROB_W-1];
		// across a wrap the larger index is the older one
		if (same_wrap) begin
			a_first = ra[RIDX_W-1:0] < rb[RIDX_W-1:0];
		end else begin
			a_first = ra[RIDX_W-1:0] > rb[RIDX_W-1:0];
		end
		return (va && vb) ? a_first : va;
	endfunction

	// lowest free slot, scan from the top so the last hit wins
	always_comb begin
		free_idx = '0;
		has_free = 1'b0;
		for (int i = QLEN - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_idx = IDX_W'(i);
				has_free = 1'b1;
			end
		end
	end

	assign full = !has_free;
	// pulse while full is dropped
	assign disp_ok = disp_en && has_free;

	assign disp_rdy1 = disp_src1_ready || wake_hit(disp_src1);
	// immediate means nothing to wait for
	assign disp_rdy2 = disp_use_imm || disp_src2_ready
		|| wake_hit(disp_op2.tag_view[`IQ_PREG_W-1:0]);

	// oldest-first select, evaluated leaves up
	always_comb begin
		for (int k = 0; k < QLEN; k++) begin
			node_v[QLEN+k] = valid[k] && rdy1[k] && rdy2[k];
			node_id[QLEN+k] = IDX_W'(k);
			node_rob[QLEN+k] = rob_q[k];
		end
		for (int k = QLEN - 1; k >= 1; k--) begin
			node_v[k] = node_v[2*k] || node_v[2*k+1];
			if (is_older(node_v[2*k], node_rob[2*k], node_v[2*k+1], node_rob[2*k+1])) begin
				node_id[k] = node_id[2*k];
				node_rob[k] = node_rob[2*k];
			end else begin
				node_id[k] = node_id[2*k+1];
				node_rob[k] = node_rob[2*k+1];
			end
		end
	end

	assign chosen = node_id[1];
	assign issue_go = node_v[1] && !stall;

	// issued op straight out of the chosen slot
	assign iq.valid = node_v[1];
	assign iq.op = op_q[chosen];
	assign iq.rob = rob_q[chosen];
	assign iq.dst = dst_q[chosen];
	assign iq.src1 = src1_q[chosen];
	assign iq.use_imm = use_imm_q[chosen];
	assign iq.op2 = op2_q[chosen];

	// valid and ready flags
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			rdy1 <= '0;
			rdy2 <= '0;
		end else begin
			// wakeup keeps running under stall
			for (int i = 0; i < QLEN; i++) begin
				if (valid[i] && wake_hit(src1_q[i])) begin
					rdy1[i] <= 1'b1;
				end
				if (valid[i] && !use_imm_q[i]
					&& wake_hit(op2_q[i].tag_view[`IQ_PREG_W-1:0])) begin
					rdy2[i] <= 1'b1;
				end
			end
			if (issue_go) begin
				valid[chosen] <= 1'b0;
			end
			// free slot is never the chosen one
			if (disp_ok) begin
				valid[free_idx] <= 1'b1;
				rdy1[free_idx] <= disp_rdy1;
				rdy2[free_idx] <= disp_rdy2;
			end
		end
	end

	// payload, written on dispatch only
	always_ff @(posedge clk) begin
		if (disp_ok) begin
			op_q[free_idx] <= disp_op;
			rob_q[free_idx] <= disp_rob;
			dst_q[free_idx] <= disp_dst;
			src1_q[free_idx] <= disp_src1;
			use_imm_q[free_idx] <= disp_use_imm;
			op2_q[free_idx] <= disp_op2;
		end
	end

endmodule

// ==== alu_issue_chk.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module alu_issue_chk (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic full,
	input logic wb_valid,
	input logic [`IQ_PREG_W-1:0] wb_tag
);
	// number of failed assertions so far
	int fail_cnt = 0;

	// empty queue and no result in the first cycle out of reset
	a_reset_clean: assert property (@(posedge clk) $fell(reset) |-> (!wb_valid && !full))
		else begin
			fail_cnt++;
			$error("wb_valid or full high in the first cycle after reset");
		end

	// a stalled cycle leaves a bubble in the exec register
	a_stall_bubble: assert property (@(posedge clk) disable iff (reset)
		stall |=> !$rose(wb_valid))
		else begin
			fail_cnt++;
			$error("wb_valid rose right after a stalled cycle");
		end

	// tag feeds regfile write and wake 0
	a_tag_known: assert property (@(posedge clk) disable iff (reset)
		wb_valid |-> !$isunknown(wb_tag))
		else begin
			fail_cnt++;
			$error("wb_tag unknown while wb_valid is high");
		end

endmodule

bind alu_issue_top alu_issue_chk u_chk (
	.clk(clk),
	.reset(reset),
	.stall(stall),
	.full(full),
	.wb_valid(wb_valid),
	.wb_tag(wb_tag)
);

// ==== alu_issue_top.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module alu_issue_top
	import iq_pkg::*;
(
	input logic clk,
	input logic reset,
	// dispatch
	input logic disp_en,
	input logic [`IQ_OP_W-1:0] disp_op,
	input logic [`IQ_ROB_W-1:0] disp_rob,
	input logic [`IQ_PREG_W-1:0] disp_dst,
	input logic [`IQ_PREG_W-1:0] disp_src1,
	input logic disp_src1_ready,
	input logic disp_use_imm,
	input op2_u disp_op2,
	input logic disp_src2_ready,
	input logic stall,
	// external writeback, load unit stand-in
	input logic ext_wr_en,
	input logic [`IQ_PREG_W-1:0] ext_wr_tag,
	input logic [`IQ_XLEN-1:0] ext_wr_data,
	output logic full,
	output logic wb_valid,
	output logic [`IQ_PREG_W-1:0] wb_tag,
	output logic [`IQ_XLEN-1:0] wb_data
);
	issue_if iss ();

	logic [`IQ_WAKE_NUM-1:0] wake_valid;
	logic [`IQ_WAKE_NUM-1:0][`IQ_PREG_W-1:0] wake_tag;
	logic [`IQ_PREG_W-1:0] rf_addr1;
	logic [`IQ_PREG_W-1:0] rf_addr2;
	logic [`IQ_XLEN-1:0] rf_data1;
	logic [`IQ_XLEN-1:0] rf_data2;

	// wake 0 from alu writeback, wake 1 from ext port
	assign wake_valid = {ext_wr_en, wb_valid};
	assign wake_tag = {ext_wr_tag, wb_tag};

	alu_iqueue #(
		.QLEN(`IQ_QLEN)
	) u_iqueue (
		.clk(clk),
		.reset(reset),
		.disp_en(disp_en),
		.stall(stall),
		.disp_op(disp_op),
		.disp_rob(disp_rob),
		.disp_dst(disp_dst),
		.disp_src1(disp_src1),
		.disp_src1_ready(disp_src1_ready),
		.disp_use_imm(disp_use_imm),
		.disp_op2(disp_op2),
		.disp_src2_ready(disp_src2_ready),
		.wake_valid(wake_valid),
		.wake_tag(wake_tag),
		.full(full),
		.iq(iss.issue)
	);

	phys_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.rd_addr1(rf_addr1),
		.rd_addr2(rf_addr2),
		.rd_data1(rf_data1),
		.rd_data2(rf_data2),
		.wr_en0(wb_valid),
		.wr_tag0(wb_tag),
		.wr_data0(wb_data),
		.wr_en1(ext_wr_en),
		.wr_tag1(ext_wr_tag),
		.wr_data1(ext_wr_data)
	);

	alu_exec u_exec (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.ex(iss.exec),
		.rf_addr1(rf_addr1),
		.rf_addr2(rf_addr2),
		.rf_data1(rf_data1),
		.rf_data2(rf_data2),
		.wb_valid(wb_valid),
		.wb_tag(wb_tag),
		.wb_data(wb_data)
	);

endmodule

// ==== iq_consts.svh ====
`ifndef IQ_CONSTS_SVH
`define IQ_CONSTS_SVH

// datapath widths
`define IQ_XLEN 32
// 64 physical registers
`define IQ_PREG_W 6
// wrap bit on top of a 5-bit rob index
`define IQ_ROB_W 6
`define IQ_OP_W 3
`define IQ_IMM_W 12

// queue depth, 4 / 8 / 16 all fine
`define IQ_QLEN 8
// wake 0 = alu writeback, wake 1 = external (load) writeback
`define IQ_WAKE_NUM 2

// alu op codes
`define IQ_OP_ADD 3'd0
`define IQ_OP_SUB 3'd1
`define IQ_OP_AND 3'd2
`define IQ_OP_OR 3'd3
`define IQ_OP_XOR 3'd4
`define IQ_OP_SLL 3'd5
`define IQ_OP_SRL 3'd6
`define IQ_OP_SLT 3'd7

`endif

// ==== iq_pkg.sv ====
`include "iq_consts.svh"

package iq_pkg;

	// second operand field, decoded by use_imm
	// use_imm clear: source 2 tag in the low bits, padding above
	// use_imm set: immediate, sign extended by the execute stage
	typedef union packed {
		logic [`IQ_IMM_W-1:0] tag_view;
		logic signed [`IQ_IMM_W-1:0] imm;
	} op2_u;

	// tag width always fits below the immediate
	localparam int OP2_PAD_W = `IQ_IMM_W - `IQ_PREG_W;

endpackage

// ==== issue_if.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

// one issued operation, queue to execute
interface issue_if
	import iq_pkg::*;
();
	// level, only counts while stall is low
	logic valid;
	logic [`IQ_OP_W-1:0] op;
	logic [`IQ_ROB_W-1:0] rob;
	logic [`IQ_PREG_W-1:0] dst;
	logic [`IQ_PREG_W-1:0] src1;
	// selects which view of op2 is live
	logic use_imm;
	op2_u op2;

	// queue side
	modport issue (
		output valid, op, rob, dst, src1, use_imm, op2
	);

	// execute side
	modport exec (
		input valid, op, rob, dst, src1, use_imm, op2
	);

endinterface

// ==== phys_regfile.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module phys_regfile (
	input logic clk,
	input logic reset,
	input logic [`IQ_PREG_W-1:0] rd_addr1,
	input logic [`IQ_PREG_W-1:0] rd_addr2,
	output logic [`IQ_XLEN-1:0] rd_data1,
	output logic [`IQ_XLEN-1:0] rd_data2,
	// port 0, alu writeback
	input logic wr_en0,
	input logic [`IQ_PREG_W-1:0] wr_tag0,
	input logic [`IQ_XLEN-1:0] wr_data0,
	// port 1, external writeback
	input logic wr_en1,
	input logic [`IQ_PREG_W-1:0] wr_tag1,
	input logic [`IQ_XLEN-1:0] wr_data1
);
	localparam int NREG = 1 << `IQ_PREG_W;

	logic [`IQ_XLEN-1:0] regs [NREG];

	// async read
	// a woken source reads here one cycle after the write
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	always_ff @(posedge clk) begin
		if (reset) begin
			// whole file back to zero
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// port 1 first so port 0 overrides on a tag clash
			if (wr_en1) begin
				regs[wr_tag1] <= wr_data1;
			end
			if (wr_en0) begin
				regs[wr_tag0] <= wr_data0;
			end
		end
	end

endmodule

// ==== tb.f ====
+incdir+.
iq_pkg.sv
issue_if.sv
alu_iqueue.sv
phys_regfile.sv
alu_exec.sv
alu_issue_top.sv
alu_issue_chk.sv
tb_alu_issue.sv

// ==== tb_alu_issue.sv ====
`timescale 1ns/1ps
`include "iq_consts.svh"

module tb_alu_issue
	import iq_pkg::*;
();
	logic clk;
	logic reset;
	logic disp_en;
	logic [`IQ_OP_W-1:0] disp_op;
	logic [`IQ_ROB_W-1:0] disp_rob;
	logic [`IQ_PREG_W-1:0] disp_dst;
	logic [`IQ_PREG_W-1:0] disp_src1;
	logic disp_src1_ready;
	logic disp_use_imm;
	op2_u disp_op2;
	logic disp_src2_ready;
	logic stall;
	logic ext_wr_en;
	logic [`IQ_PREG_W-1:0] ext_wr_tag;
	logic [`IQ_XLEN-1:0] ext_wr_data;
	logic full;
	logic wb_valid;
	logic [`IQ_PREG_W-1:0] wb_tag;
	logic [`IQ_XLEN-1:0] wb_data;

	// register values as the tb expects them
	logic [`IQ_XLEN-1:0] model [64];
	// expected and observed writebacks in arrival order
	logic [`IQ_PREG_W-1:0] exp_tag [$];
	logic [`IQ_XLEN-1:0] exp_data [$];
	logic [`IQ_PREG_W-1:0] got_tag [$];
	logic [`IQ_XLEN-1:0] got_data [$];
	integer seed;
	int errors;
	int checks;
	int test_err0;
	logic [`IQ_ROB_W-1:0] rob_next;

	alu_issue_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// collect every result mid-cycle while outputs are stable
	always @(negedge clk) begin
		if (!reset && wb_valid) begin
			got_tag.push_back(wb_tag);
			got_data.push_back(wb_data);
		end
	end

	function automatic logic [`IQ_XLEN-1:0] alu_ref(
		input logic [`IQ_OP_W-1:0] op,
		input logic [`IQ_XLEN-1:0] a,
		input logic [`IQ_XLEN-1:0] b
	);
		case (op)
			`IQ_OP_ADD: return a + b;
			`IQ_OP_SUB: return a - b;
			`IQ_OP_AND: return a & b;
			`IQ_OP_OR: return a | b;
			`IQ_OP_XOR: return a ^ b;
			// shift amount is b[4:0]
			`IQ_OP_SLL: return a << b[4:0];
			`IQ_OP_SRL: return a >> b[4:0];
			default: return {{(`IQ_XLEN - 1){1'b0}}, ($signed(a) < $signed(b))};
		endcase
	endfunction

	function automatic logic [`IQ_OP_W-1:0] rand_op();
		logic [31:0] r;
		r = $random(seed);
		return r[`IQ_OP_W-1:0];
	endfunction

	function automatic op2_u tag_op2(input logic [`IQ_PREG_W-1:0] tag);
		op2_u v;
		v.tag_view = {{OP2_PAD_W{1'b0}}, tag};
		return v;
	endfunction

	task automatic check_word(
		input string name,
		input logic [`IQ_XLEN-1:0] got,
		input logic [`IQ_XLEN-1:0] exp
	);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_tag(
		input string name,
		input logic [`IQ_PREG_W-1:0] got,
		input logic [`IQ_PREG_W-1:0] exp
	);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// called at a falling edge and returns at the next one
	task automatic dispatch(
		input logic [`IQ_OP_W-1:0] op,
		input logic [`IQ_PREG_W-1:0] dst,
		input logic [`IQ_PREG_W-1:0] src1,
		input logic src1_ready,
		input logic use_imm,
		input op2_u op2,
		input logic src2_ready
	);
		disp_en = 1'b1;
		disp_op = op;
		disp_rob = rob_next;
		disp_dst = dst;
		disp_src1 = src1;
		disp_src1_ready = src1_ready;
		disp_use_imm = use_imm;
		disp_op2 = op2;
		disp_src2_ready = src2_ready;
		rob_next = rob_next + 1'b1;
		@(negedge clk);
		disp_en = 1'b0;
	endtask

	// load unit stand-in that also wakes waiting entries
	task automatic ext_write(
		input logic [`IQ_PREG_W-1:0] tag,
		input logic [`IQ_XLEN-1:0] data
	);
		ext_wr_en = 1'b1;
		ext_wr_tag = tag;
		ext_wr_data = data;
		model[tag] = data;
		@(negedge clk);
		ext_wr_en = 1'b0;
	endtask

	task automatic expect_result(
		input logic [`IQ_PREG_W-1:0] tag,
		input logic [`IQ_XLEN-1:0] data
	);
		exp_tag.push_back(tag);
		exp_data.push_back(data);
		model[tag] = data;
	endtask

	// polled on rising edges while the queues fill on falling ones
	task automatic drain_check();
		int waited;
		waited = 0;
		while (got_tag.size() < exp_tag.size() && waited < 200) begin
			@(posedge clk);
			waited++;
		end
		if (got_tag.size() < exp_tag.size()) begin
			$display("timeout at %0t: only %0d of %0d results written back", $time,
				got_tag.size(), exp_tag.size());
			errors++;
		end
		// short grace period for stray results
		repeat (3) @(posedge clk);
		while (exp_tag.size() > 0 && got_tag.size() > 0) begin
			check_tag("wb_tag", got_tag.pop_front(), exp_tag.pop_front());
			check_word("wb_data", got_data.pop_front(), exp_data.pop_front());
		end
		if (got_tag.size() > 0) begin
			$display("%0d writeback results arrived that no test expected", got_tag.size());
			errors++;
		end
		got_tag.delete();
		got_data.delete();
		exp_tag.delete();
		exp_data.delete();
		@(negedge clk);
	endtask

	task automatic finish_test(input string name);
		$display("test %s done, %0d errors", name, errors - test_err0);
	endtask

	task automatic test_reset();
		test_err0 = errors;
		@(negedge clk);
		check_bit("full", full, 1'b0);
		check_bit("wb_valid", wb_valid, 1'b0);
		finish_test("reset");
	endtask

	task automatic test_single();
		logic [`IQ_OP_W-1:0] op;
		test_err0 = errors;
		ext_write(6'd1, $random(seed));
		ext_write(6'd2, $random(seed));
		op = rand_op();
		dispatch(op, 6'd10, 6'd1, 1'b1, 1'b0, tag_op2(6'd2), 1'b1);
		expect_result(6'd10, alu_ref(op, model[1], model[2]));
		drain_check();
		finish_test("single op");
	endtask

	task automatic test_chain();
		logic [`IQ_OP_W-1:0] ops [4];
		logic [`IQ_XLEN-1:0] late;
		test_err0 = errors;
		ext_write(6'd3, $random(seed));
		ext_write(6'd4, $random(seed));
		late = $random(seed);
		for (int k = 0; k < 4; k++) begin
			ops[k] = rand_op();
		end
		// r20 to r23 form a chain and r22 also waits for r5 from ext
		dispatch(ops[0], 6'd20, 6'd3, 1'b1, 1'b0, tag_op2(6'd4), 1'b1);
		dispatch(ops[1], 6'd21, 6'd20, 1'b0, 1'b0, tag_op2(6'd4), 1'b1);
		dispatch(ops[2], 6'd22, 6'd21, 1'b0, 1'b0, tag_op2(6'd5), 1'b0);
		dispatch(ops[3], 6'd23, 6'd22, 1'b0, 1'b0, tag_op2(6'd4), 1'b1);
		expect_result(6'd20, alu_ref(ops[0], model[3], model[4]));
		expect_result(6'd21, alu_ref(ops[1], model[20], model[4]));
		expect_result(6'd22, alu_ref(ops[2], model[21], late));
		expect_result(6'd23, alu_ref(ops[3], model[22], model[4]));
		repeat (6) @(negedge clk);
		ext_write(6'd5, late);
		drain_check();
		finish_test("dependency chain");
	endtask

	task automatic test_age();
		logic [`IQ_ROB_W-1:0] age_rob [5];
		int order [5];
		logic [`IQ_OP_W-1:0] ops [5];
		test_err0 = errors;
		// listed oldest first with the wrap between 31 and 32
		age_rob = '{6'd28, 6'd30, 6'd31, 6'd32, 6'd33};
		order = '{3, 1, 4, 0, 2};
		stall = 1'b1;
		for (int k = 0; k < 5; k++) begin
			ops[k] = rand_op();
		end
		for (int i = 0; i < 5; i++) begin
			rob_next = age_rob[order[i]];
			dispatch(ops[order[i]], 6'(40 + order[i]), 6'd1, 1'b1, 1'b0, tag_op2(6'd2), 1'b1);
			check_bit("wb_valid", wb_valid, 1'b0);
		end
		repeat (4) begin
			@(negedge clk);
			check_bit("wb_valid", wb_valid, 1'b0);
		end
		for (int k = 0; k < 5; k++) begin
			expect_result(6'(40 + k), alu_ref(ops[k], model[1], model[2]));
		end
		stall = 1'b0;
		drain_check();
		finish_test("age order");
	endtask

	task automatic test_fill();
		logic [`IQ_OP_W-1:0] ops [`IQ_QLEN];
		test_err0 = errors;
		stall = 1'b1;
		for (int i = 0; i < `IQ_QLEN; i++) begin
			ops[i] = rand_op();
			dispatch(ops[i], 6'(24 + i), 6'd2, 1'b1, 1'b0, tag_op2(6'd1), 1'b1);
		end
		check_bit("full", full, 1'b1);
		for (int i = 0; i < `IQ_QLEN; i++) begin
			expect_result(6'(24 + i), alu_ref(ops[i], model[2], model[1]));
		end
		stall = 1'b0;
		drain_check();
		check_bit("full", full, 1'b0);
		finish_test("fill and drain");
	endtask

	task automatic test_imm();
		logic [31:0] r;
		logic [`IQ_IMM_W-1:0] imm;
		logic [`IQ_PREG_W-1:0] src;
		op2_u v;
		test_err0 = errors;
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			imm = r[`IQ_IMM_W-1:0];
			v.imm = imm;
			src = i[0] ? 6'd1 : 6'd2;
			// every op code twice with src2 ready clear since use_imm covers it
			dispatch(3'(i), 6'(48 + i), src, 1'b1, 1'b1, v, 1'b0);
			expect_result(6'(48 + i), alu_ref(3'(i), model[src],
				{{(`IQ_XLEN - `IQ_IMM_W){imm[`IQ_IMM_W-1]}}, imm}));
		end
		drain_check();
		finish_test("immediate ops");
	endtask

	initial begin
		seed = 32'h9865;
		errors = 0;
		checks = 0;
		rob_next = '0;
		for (int i = 0; i < 64; i++) begin
			model[i] = '0;
		end
		reset = 1'b1;
		disp_en = 1'b0;
		disp_op = '0;
		disp_rob = '0;
		disp_dst = '0;
		disp_src1 = '0;
		disp_src1_ready = 1'b0;
		disp_use_imm = 1'b0;
		disp_op2 = '0;
		disp_src2_ready = 1'b0;
		stall = 1'b0;
		ext_wr_en = 1'b0;
		ext_wr_tag = '0;
		ext_wr_data = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		test_reset();
		test_single();
		test_chain();
		test_age();
		test_fill();
		test_imm();
		// assertion failures from the bound checker
		errors = errors + uut.u_chk.fail_cnt;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
